// File: Bender.yml
package:
  name: sysmon

sources:
  - logic/sysmon_pkg.sv
  - logic/sample_decode.sv
  - logic/alarm_execute.sv
  - logic/result_store.sv
  - logic/monitor_apb_port.sv
  - logic/sysmon_top.sv
  - target: test
    files:
      - dv/sysmon_tb.sv

// File: dv/sysmon_tb.sv
`timescale 1ns/1ps

module sysmon_tb;

   typedef struct packed {
      logic [7:0]  op;                             // Opcode letter
      logic [15:0] a;                              // Channel, address, alarm or count
      logic [15:0] b;                              // Word or bus data
      logic [15:0] c;                              // Expected pslverr
      logic [15:0] line_no;                        // Trace line for messages
   } trace_op_t;

   logic                reset = 1'b0;              // Clock
   logic                lb_clk;                    // Active-high async reset
   sysmon_pkg::conv_t   conv;
   logic [7:0]          paddr;
   logic                psel;
   logic                penable;
   logic                pwrite;
   logic [15:0]         pwdata;
   logic [15:0]         prdata;
   logic                pready;
   logic                pslverr;
   logic [7:0]          alarm;

   trace_op_t trace_q[$];                          // Operations in file order
   int        cycle_count  = 0;
   int        cycle_limit  = 100;                  // Raised once the trace is loaded
   int        check_errors = 0;
   int        run_errors   = 0;                    // Handshake and trace format

   sysmon_top i_sysmon_top (.*);

   always #5 reset = ~reset;                       // 10 ns period

   always @(posedge reset) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         $display("Timeout: run went past %0d clock cycles", cycle_limit);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   task automatic check_value(input string what, input logic [15:0] actual,
                              input logic [15:0] expected);
      if (actual !== expected) begin
         check_errors++;
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, actual, expected);
      end
   endtask

   task automatic load_trace(output bit ok);
      int          fd;
      int          line_no;
      string       line;
      logic [7:0]  op;
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] c;
      fd      = $fopen("dv/sysmon_trace.txt", "r");
      ok      = (fd != 0);
      line_no = 0;
      while (ok && !$feof(fd)) begin
         line_no++;
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 1 && line[0] != "#") begin  // Skip blanks and comments
            op = "?";
            a  = '0;
            b  = '0;
            c  = '0;
            void'($sscanf(line, "%c %h %h %h", op, a, b, c));
            trace_q.push_back('{op: op, a: a, b: b, c: c, line_no: 16'(line_no)});
         end
      end
      if (ok) begin
         $fclose(fd);
      end
      cycle_limit = 40 * line_no + 100;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge reset);
         #1;
      end
   endtask

   // One converter result valid for a single cycle
   task automatic apply_sample(input logic [4:0] ch, input logic [15:0] word);
      conv = {1'b1, ch, word};
      @(posedge reset);
      #1;
      conv = '0;
   endtask

   task automatic apb_transfer(input logic [7:0] addr, input logic wr, input logic [15:0] wdata,
                               output logic [15:0] rdata, output logic err);
      int waits;
      paddr   = addr;                              // Setup phase
      pwrite  = wr;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge reset);
      #1;
      penable = 1'b1;                              // Access phase
      waits   = 0;
      @(negedge reset);
      while (!pready && waits < 8) begin
         waits++;
         @(negedge reset);
      end
      if (!pready) begin
         run_errors++;
         $display("APB transfer to address %h never got pready", addr);
      end else begin
         // One wait state, pready on the second access cycle
         check_value($sformatf("APB %h wait states", addr), 16'(waits), 16'd1);
      end
      rdata = prdata;                              // Stable mid-cycle
      err   = pslverr;
      @(posedge reset);                            // Completing edge
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic run_op(input trace_op_t t);
      logic [15:0] rdata;
      logic        err;
      string       tag;
      tag = $sformatf("line %0d op %c", t.line_no, t.op);
      case (t.op)
         "S": apply_sample(t.a[4:0], t.b);
         "W", "R": begin
            apb_transfer(t.a[7:0], t.op == "W", t.b, rdata, err);
            check_value({tag, " pslverr"}, {15'd0, err}, t.c);
            if (t.op == "R" && t.c == 16'd0) begin
               check_value({tag, " prdata"}, rdata, t.b);  // Data only on good reads
            end
         end
         "A": check_value({tag, " alarm port"}, {8'h00, alarm}, t.a);
         "D": idle_cycles(t.a);
         default: begin
            run_errors++;
            $display("Unknown opcode in trace at %s", tag);
         end
      endcase
   endtask

   initial begin : main
      bit         ok;
      logic [7:0] prev_op;
      lb_clk  = 1'b1;                              // Reset held from time 0
      conv    = '0;
      paddr   = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      pwdata  = '0;
      prev_op = "D";
      void'($urandom(16597));
      load_trace(ok);
      if (!ok) begin
         $display("Cannot open trace file dv/sysmon_trace.txt");
         $display("Simulation finished: FAIL");
         $finish;
      end else begin
         repeat (4) @(posedge reset);
         #1 lb_clk = 1'b0;
         foreach (trace_q[i]) begin
            // Random gap except inside sample bursts
            if (trace_q[i].op != "D" && !(trace_q[i].op == "S" && prev_op == "S")) begin
               idle_cycles($urandom % 4);
            end
            run_op(trace_q[i]);
            prev_op = trace_q[i].op;
         end
         idle_cycles(2);
         $display("Errors: %0d check, %0d other, over %0d trace operations",
                  check_errors, run_errors, trace_q.size());
         if (check_errors == 0 && run_errors == 0) begin
            $display("Simulation finished: PASS");
         end else begin
            $display("Simulation finished: FAIL");
         end
         $finish;
      end
   end

endmodule

// File: dv/sysmon_trace.txt
# Fields in hex: S chan word | W addr data err | R addr data err | A alarm | D cycles
# R compares data only when err is 0; D 2 lets a sample reach the store
R 9c 7fff 0
R a0 8000 0
R 00 0000 0
R 7c 0000 0
R c0 0000 0
A 00
S 03 abc5
S 14 f005
D 2
R 0c 0abc 0
R 50 ff00 0
W 80 0100 0
W a4 0100 0
R 80 0100 0
R a4 0100 0
S 00 2000
S 01 0105
D 2
A 03
R c0 0003 0
S 00 0500
S 01 4000
D 2
A 00
R c0 0000 0
S 05 1110
S 06 2220
S 17 8000
S 08 fff0
D 2
R 18 0222 0
R 5c f800 0
R 20 0fff 0
W 0c 1234 1
W c0 00ff 1
R c4 0000 1
W e0 5555 1
R 0c 0abc 0
R 80 0100 0
A 00

// File: logic/alarm_execute.sv
`timescale 1ns/1ps

module alarm_execute (
   input  logic                                  reset,          // Clock
   input  logic                                  lb_clk,         // Async reset, high
   input  sysmon_pkg::sample_t                   sample,         // From decode
   input  sysmon_pkg::limit_wr_t                 limit_wr,       // From APB port
   input  logic [sysmon_pkg::alarm_idx_w-1:0]    limit_rd_idx,   // Read-back index
   input  logic                                  limit_rd_lower, // Read-back bank
   output logic [sysmon_pkg::data_w-1:0]         limit_rd_data,
   output sysmon_pkg::sample_t                   store_wr,       // To result store
   output logic [sysmon_pkg::num_alarm_chan-1:0] alarm           // One bit per channel
);

   logic signed [sysmon_pkg::data_w-1:0] upper [sysmon_pkg::num_alarm_chan];
   logic signed [sysmon_pkg::data_w-1:0] lower [sysmon_pkg::num_alarm_chan];
   logic                                 has_limit;   // Channel 0..7
   logic [sysmon_pkg::alarm_idx_w-1:0]   idx;
   logic                                 out_of_range;
   logic                                 wr_valid_q;
   logic [sysmon_pkg::chan_w-1:0]        wr_channel_q;
   logic signed [sysmon_pkg::data_w-1:0] wr_value_q;

   assign has_limit = sample.channel < sysmon_pkg::chan_w'(sysmon_pkg::num_alarm_chan);
   assign idx       = sample.channel[sysmon_pkg::alarm_idx_w-1:0];

   // Signed compare against the channel's window
   assign out_of_range = (sample.value > upper[idx]) || (sample.value < lower[idx]);

   always_ff @(posedge reset or posedge lb_clk) begin
      if (lb_clk) begin
         for (int i = 0; i < sysmon_pkg::num_alarm_chan; i++) begin
            upper[i] <= sysmon_pkg::limit_upper_rst;
            lower[i] <= sysmon_pkg::limit_lower_rst;
         end
      end else if (limit_wr.en) begin
         if (limit_wr.sel_lower) begin
            lower[limit_wr.idx] <= limit_wr.data;
         end else begin
            upper[limit_wr.idx] <= limit_wr.data;
         end
      end
   end

   always_ff @(posedge reset or posedge lb_clk) begin
      if (lb_clk) begin
         alarm      <= '0;
         wr_valid_q <= 1'b0;
      end else begin
         if (sample.valid && has_limit) begin
            alarm[idx] <= out_of_range;           // Latest sample decides
         end
         wr_valid_q <= sample.valid;
      end
   end

   // Sample payload toward the store
   always_ff @(posedge reset) begin
      if (sample.valid) begin
         wr_channel_q <= sample.channel;
         wr_value_q   <= sample.value;
      end
   end

   assign store_wr = '{valid: wr_valid_q, channel: wr_channel_q, value: wr_value_q};

   assign limit_rd_data = limit_rd_lower ? lower[limit_rd_idx] : upper[limit_rd_idx];

endmodule

// File: logic/monitor_apb_port.sv
`timescale 1ns/1ps

module monitor_apb_port (
   input  logic                                  reset,          // Clock
   input  logic                                  lb_clk,         // Async reset, high
   input  logic [7:0]                            paddr,
   input  logic                                  psel,
   input  logic                                  penable,
   input  logic                                  pwrite,
   input  logic [sysmon_pkg::data_w-1:0]         pwdata,
   output logic [sysmon_pkg::data_w-1:0]         prdata,
   output logic                                  pready,
   output logic                                  pslverr,
   output sysmon_pkg::limit_wr_t                 limit_wr,
   output logic [sysmon_pkg::alarm_idx_w-1:0]    limit_rd_idx,
   output logic                                  limit_rd_lower,
   input  logic [sysmon_pkg::data_w-1:0]         limit_rd_data,
   output logic [sysmon_pkg::chan_w-1:0]         store_rd_addr,
   input  logic [sysmon_pkg::data_w-1:0]         store_rd_data,
   input  logic [sysmon_pkg::num_alarm_chan-1:0] alarm
);

   logic                          in_sample;   // 0x00..0x7C
   logic                          in_upper;    // 0x80..0x9C
   logic                          in_lower;    // 0xA0..0xBC
   logic                          in_alarm;    // 0xC0
   logic                          err;
   logic                          access;      // Access phase of a transfer
   logic [sysmon_pkg::data_w-1:0] rd_mux;

   // Region decode, word aligned
   assign in_sample = ~paddr[7];
   assign in_upper  = paddr[7:5] == sysmon_pkg::addr_upper_base[7:5];
   assign in_lower  = paddr[7:5] == sysmon_pkg::addr_lower_base[7:5];
   assign in_alarm  = paddr[7:2] == sysmon_pkg::addr_alarm[7:2];

   // Read-only regions reject writes, holes reject everything
   assign err = (pwrite && (in_sample || in_alarm)) ||
                !(in_sample || in_upper || in_lower || in_alarm);

   assign access = psel && penable;

   assign store_rd_addr  = paddr[6:2];             // Store read starts in setup
   assign limit_rd_idx   = paddr[4:2];
   assign limit_rd_lower = in_lower;

   always_comb begin
      rd_mux = '0;
      if (in_sample) begin
         rd_mux = store_rd_data;                   // Valid from first access cycle
      end else if (in_upper || in_lower) begin
         rd_mux = limit_rd_data;
      end else if (in_alarm) begin
         rd_mux = {{(sysmon_pkg::data_w - sysmon_pkg::num_alarm_chan){1'b0}}, alarm};
      end
   end

   // pready doubles as the wait-state count, high on second access cycle
   always_ff @(posedge reset or posedge lb_clk) begin
      if (lb_clk) begin
         pready  <= 1'b0;
         pslverr <= 1'b0;
      end else begin
         pready  <= access && !pready;
         pslverr <= access && !pready && err;
      end
   end

   always_ff @(posedge reset) begin
      if (access && !pready) begin
         prdata <= (pwrite || err) ? '0 : rd_mux;
      end
   end

   // Limit write lands on the completing edge
   assign limit_wr = '{en:        access && pready && pwrite && !err,
                       sel_lower: in_lower,
                       idx:       paddr[4:2],
                       data:      pwdata};

endmodule

// File: logic/result_store.sv
`timescale 1ns/1ps

module result_store (
   input  logic                          reset,   // Clock, both ports
   input  logic                          lb_clk,  // Async reset, high
   input  sysmon_pkg::sample_t           wr,      // Write port
   input  logic [sysmon_pkg::chan_w-1:0] rd_addr, // Read port address
   output logic [sysmon_pkg::data_w-1:0] rd_data  // One cycle after rd_addr
);

   logic [sysmon_pkg::data_w-1:0] mem [sysmon_pkg::num_chan];

   // Write side, latest value per channel
   always_ff @(posedge reset or posedge lb_clk) begin
      if (lb_clk) begin
         for (int i = 0; i < sysmon_pkg::num_chan; i++) begin
            mem[i] <= '0;                          // Reads 0 until first sample
         end
      end else if (wr.valid) begin
         mem[wr.channel] <= wr.value;
      end
   end

   // Read side, registered output
   always_ff @(posedge reset or posedge lb_clk) begin
      if (lb_clk) begin
         rd_data <= '0;
      end else begin
         rd_data <= mem[rd_addr];                  // Old data on same-address write
      end
   end

endmodule

// File: logic/sample_decode.sv
`timescale 1ns/1ps

module sample_decode #(
   parameter logic [sysmon_pkg::num_chan-1:0] bipolar_mask = 32'hFFFF_0000
) (
   input  logic                reset,             // Clock
   input  logic                lb_clk,            // Active-high async reset
   input  sysmon_pkg::conv_t   conv,              // Converter result
   output sysmon_pkg::sample_t sample             // Registered decoded sample
);

   logic                                 is_bipolar;   // Channel's mask bit
   logic signed [sysmon_pkg::data_w-1:0] value_ext;    // Extended code
   logic                                 valid_q;
   logic [sysmon_pkg::chan_w-1:0]        channel_q;
   logic signed [sysmon_pkg::data_w-1:0] value_q;

   assign is_bipolar = bipolar_mask[conv.channel];

   // Sign-extend the bipolar view and zero-extend the unipolar one
   always_comb begin
      if (is_bipolar) begin
         value_ext = {{(sysmon_pkg::data_w - sysmon_pkg::code_w)
                         {conv.word.bip.code[sysmon_pkg::code_w-1]}},
                      conv.word.bip.code};
      end else begin
         value_ext = {{(sysmon_pkg::data_w - sysmon_pkg::code_w){1'b0}},
                      conv.word.uni.code};
      end
   end

   always_ff @(posedge reset or posedge lb_clk) begin
      if (lb_clk) begin
         valid_q <= 1'b0;                         // Nothing in flight
      end else begin
         valid_q <= conv.valid;                   // One stage per result
      end
   end

   always_ff @(posedge reset) begin
      if (conv.valid) begin
         channel_q <= conv.channel;
         value_q   <= value_ext;
      end
   end

   assign sample = '{valid: valid_q, channel: channel_q, value: value_q};

endmodule

// File: logic/sysmon_pkg.sv
package sysmon_pkg;

   localparam int chan_w         = 5;             // Converter channel number
   localparam int num_chan       = 32;            // Channels held in the result store
   localparam int num_alarm_chan = 8;             // Channels 0..7 carry limits
   localparam int alarm_idx_w    = 3;             // Limit register index
   localparam int code_w         = 12;            // ADC code in the top bits
   localparam int data_w         = 16;            // Decoded value and bus data

   // Conversion word, read as unsigned or two's-complement code
   typedef union packed {
      struct packed {
         logic [code_w-1:0]        code;          // Temperature and supplies
         logic [data_w-code_w-1:0] flags;         // Low flag bits
      } uni;
      struct packed {
         logic signed [code_w-1:0] code;          // Auxiliary inputs
         logic [data_w-code_w-1:0] flags;         // Same low bits
      } bip;
   } conv_word_u;

   typedef struct packed {
      logic              valid;                   // Data-ready pulse
      logic [chan_w-1:0] channel;                 // Sequencer channel
      conv_word_u        word;                    // Raw conversion word
   } conv_t;

   typedef struct packed {
      logic                     valid;            // Sample present
      logic [chan_w-1:0]        channel;          // Source channel
      logic signed [data_w-1:0] value;            // Extended code
   } sample_t;

   typedef struct packed {
      logic                   en;                 // Write strobe
      logic                   sel_lower;          // 1 picks the lower bank
      logic [alarm_idx_w-1:0] idx;                // Channel 0..7
      logic [data_w-1:0]      data;               // New limit
   } limit_wr_t;

   // APB byte address map
   localparam logic [7:0] addr_upper_base = 8'h80; // 0x80..0x9C
   localparam logic [7:0] addr_lower_base = 8'hA0; // 0xA0..0xBC
   localparam logic [7:0] addr_alarm      = 8'hC0; // Alarm status word

   // Widest window, nothing trips after reset
   localparam logic signed [data_w-1:0] limit_upper_rst = 16'sh7FFF;
   localparam logic signed [data_w-1:0] limit_lower_rst = 16'sh8000;

endpackage

// File: logic/sysmon_top.sv
`timescale 1ns/1ps

module sysmon_top #(
   parameter logic [sysmon_pkg::num_chan-1:0] bipolar_mask = 32'hFFFF_0000 // Aux channels 16..31
) (
   input  logic                                  reset,   // Clock
   input  logic                                  lb_clk,  // Async reset, high
   input  sysmon_pkg::conv_t                     conv,    // Converter result stream
   input  logic [7:0]                            paddr,
   input  logic                                  psel,
   input  logic                                  penable,
   input  logic                                  pwrite,
   input  logic [sysmon_pkg::data_w-1:0]         pwdata,
   output logic [sysmon_pkg::data_w-1:0]         prdata,
   output logic                                  pready,
   output logic                                  pslverr,
   output logic [sysmon_pkg::num_alarm_chan-1:0] alarm
);

   sysmon_pkg::sample_t                sample;          // Decode to execute
   sysmon_pkg::sample_t                store_wr;        // Execute to result
   sysmon_pkg::limit_wr_t              limit_wr;
   logic [sysmon_pkg::alarm_idx_w-1:0] limit_rd_idx;
   logic                               limit_rd_lower;
   logic [sysmon_pkg::data_w-1:0]      limit_rd_data;
   logic [sysmon_pkg::chan_w-1:0]      store_rd_addr;
   logic [sysmon_pkg::data_w-1:0]      store_rd_data;

   sample_decode #(
      .bipolar_mask (bipolar_mask)
   ) i_decode (
      .reset  (reset),
      .lb_clk (lb_clk),
      .conv   (conv),
      .sample (sample)
   );

   alarm_execute i_execute (
      .reset          (reset),
      .lb_clk         (lb_clk),
      .sample         (sample),
      .limit_wr       (limit_wr),
      .limit_rd_idx   (limit_rd_idx),
      .limit_rd_lower (limit_rd_lower),
      .limit_rd_data  (limit_rd_data),
      .store_wr       (store_wr),
      .alarm          (alarm)
   );

   result_store i_result (
      .reset   (reset),
      .lb_clk  (lb_clk),
      .wr      (store_wr),
      .rd_addr (store_rd_addr),
      .rd_data (store_rd_data)
   );

   monitor_apb_port i_apb (
      .reset          (reset),
      .lb_clk         (lb_clk),
      .paddr          (paddr),
      .psel           (psel),
      .penable        (penable),
      .pwrite         (pwrite),
      .pwdata         (pwdata),
      .prdata         (prdata),
      .pready         (pready),
      .pslverr        (pslverr),
      .limit_wr       (limit_wr),
      .limit_rd_idx   (limit_rd_idx),
      .limit_rd_lower (limit_rd_lower),
      .limit_rd_data  (limit_rd_data),
      .store_rd_addr  (store_rd_addr),
      .store_rd_data  (store_rd_data),
      .alarm          (alarm)
   );

endmodule

// File: verilog.f
logic/sysmon_pkg.sv
logic/sample_decode.sv
logic/alarm_execute.sv
logic/result_store.sv
logic/monitor_apb_port.sv
logic/sysmon_top.sv
dv/sysmon_tb.sv
